// File: sim.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_bus_master.sv
verilog/lsu_result.sv
verilog/axi_sram.sv
verilog/mem_subsys_top.sv
test/tb_mem_subsys.sv

// File: test/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsys;

    localparam int N_WORDS = 8;
    // request counts of the five tests in the order they run.
    localparam int N_REQ = N_WORDS * 2 + N_WORDS * 3 + N_WORDS * 4 + 4 * 5 + 4 * 3;
    localparam int CYCLE_LIMIT = N_REQ * (`SRAM_MAX_LAT * 2 + 10 + 3) + 10;

    logic             clk;
    logic             rst;
    logic             req_valid;
    lsu_pkg::mem_op_e req_op;
    axi_pkg::addr_t   req_addr;
    axi_pkg::data_t   req_wdata;
    logic             req_ready;
    logic             rsp_valid;
    axi_pkg::data_t   rsp_rdata;
    logic             rsp_err;
    logic             rsp_ready;

    logic [7:0]       ref_mem [0:`SRAM_WORDS*4-1];
    int               word_idx [N_WORDS];
    axi_pkg::data_t   exp_rdata;
    logic             exp_err;
    logic             lsu_pending;
    int               seed = 59;
    int               err_count = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;
    int               req_count = 0;
    int               cycle_count = 0;
    int               errs_before = 0;
    int               test_num = 0;

    mem_subsys_top uut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .rsp_ready(rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: no finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // an operation is pending from its acceptance until its response is taken.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lsu_pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            lsu_pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            lsu_pending <= 1'b0;
        end
    end

    a_rsp_rdata : assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_rdata == exp_rdata)
        else begin
            $display("MISMATCH time=%0t signal=rsp_rdata expected=%h observed=%h",
                     $time, $sampled(exp_rdata), $sampled(rsp_rdata));
            err_count++;
        end

    a_rsp_err : assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_err == exp_err)
        else begin
            $display("MISMATCH time=%0t signal=rsp_err expected=%b observed=%b",
                     $time, $sampled(exp_err), $sampled(rsp_err));
            err_count++;
        end

    a_rsp_hold : assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err))
        else begin
            $display("time=%0t response dropped or changed while rsp_ready was low", $time);
            err_count++;
        end

    a_req_ready : assert property (@(posedge clk) disable iff (rst)
        req_ready == !lsu_pending)
        else begin
            $display("MISMATCH time=%0t signal=req_ready expected=%b observed=%b",
                     $time, !$sampled(lsu_pending), $sampled(req_ready));
            err_count++;
        end

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic axi_pkg::addr_t word_addr(input int i, input int offset);
        return axi_pkg::addr_t'(word_idx[i] * 4 + offset);
    endfunction

    function automatic logic predict_err(input lsu_pkg::mem_op_e op, input axi_pkg::addr_t addr);
        logic misaligned;
        misaligned = 1'b0;
        if (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) misaligned = addr[0];
        if (op inside {lsu_pkg::LW, lsu_pkg::SW}) misaligned = (addr[1:0] != 2'b00);
        return misaligned || ((addr >> 2) >= `SRAM_WORDS);
    endfunction

    function automatic axi_pkg::data_t predict_rdata(input lsu_pkg::mem_op_e op,
                                                     input axi_pkg::addr_t addr);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        if (predict_err(op, addr)) return '0;
        base = int'(addr);
        b = ref_mem[base];
        h = {ref_mem[base + 1], ref_mem[base]};
        case (op)
            lsu_pkg::LB:  return {{(`DATA_W-8){b[7]}}, b};
            lsu_pkg::LBU: return {{(`DATA_W-8){1'b0}}, b};
            lsu_pkg::LH:  return {{(`DATA_W-16){h[15]}}, h};
            lsu_pkg::LHU: return {{(`DATA_W-16){1'b0}}, h};
            lsu_pkg::LW:  return {ref_mem[base + 3], ref_mem[base + 2], h};
            default:      return '0;
        endcase
    endfunction

    task automatic apply_store(input lsu_pkg::mem_op_e op, input axi_pkg::addr_t addr,
                               input axi_pkg::data_t data);
        int n;
        n = (op == lsu_pkg::SB) ? 1 : (op == lsu_pkg::SH) ? 2 : (op == lsu_pkg::SW) ? 4 : 0;
        for (int i = 0; i < n; i++) begin
            ref_mem[int'(addr) + i] = data[8*i +: 8];
        end
    endtask

    // called on a falling edge; returns on the falling edge after the response is taken.
    task automatic issue_op(input lsu_pkg::mem_op_e op, input axi_pkg::addr_t addr,
                            input axi_pkg::data_t data);
        int hold_cycles;
        hold_cycles = rand_below(4);
        while (!req_ready) @(negedge clk);
        exp_rdata = predict_rdata(op, addr);
        exp_err = predict_err(op, addr);
        req_valid = 1'b1;
        req_op = op;
        req_addr = addr;
        req_wdata = data;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        repeat (hold_cycles) @(negedge clk);
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        if (!exp_err) apply_store(op, addr, data);
        req_count++;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_op = lsu_pkg::LW;
        req_addr = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_WORDS; i++) begin
            word_idx[i] = rand_below(`SRAM_WORDS);
            issue_op(lsu_pkg::SW, word_addr(i, 0), $random(seed));
        end
        for (int i = 0; i < N_WORDS; i++) issue_op(lsu_pkg::LW, word_addr(i, 0), '0);
        finish_test("word round trip");

        for (int i = 0; i < N_WORDS; i++) begin
            issue_op(lsu_pkg::SB, word_addr(i, rand_below(4)), $random(seed));
            issue_op(lsu_pkg::SH, word_addr(i, 2 * rand_below(2)), $random(seed));
            issue_op(lsu_pkg::LW, word_addr(i, 0), '0);
        end
        finish_test("byte and half-word stores");

        for (int i = 0; i < N_WORDS; i++) begin
            issue_op(lsu_pkg::LB, word_addr(i, rand_below(4)), '0);
            issue_op(lsu_pkg::LBU, word_addr(i, rand_below(4)), '0);
            issue_op(lsu_pkg::LH, word_addr(i, 2 * rand_below(2)), '0);
            issue_op(lsu_pkg::LHU, word_addr(i, 2 * rand_below(2)), '0);
        end
        finish_test("load extension");

        for (int i = 0; i < 4; i++) begin
            issue_op(lsu_pkg::LH, word_addr(i, 1 + 2 * rand_below(2)), '0);
            issue_op(lsu_pkg::SH, word_addr(i, 1 + 2 * rand_below(2)), $random(seed));
            issue_op(lsu_pkg::LW, word_addr(i, 1 + rand_below(3)), '0);
            issue_op(lsu_pkg::SW, word_addr(i, 1 + rand_below(3)), $random(seed));
            issue_op(lsu_pkg::LW, word_addr(i, 0), '0);
        end
        finish_test("misaligned operations");

        // these addresses alias the tested words if the index were truncated.
        for (int i = 0; i < 4; i++) begin
            issue_op(lsu_pkg::SW, word_addr(i, `SRAM_WORDS * 4), $random(seed));
            issue_op(lsu_pkg::LBU, word_addr(i, `SRAM_WORDS * 4 + rand_below(4)), '0);
            issue_op(lsu_pkg::LW, word_addr(i, 0), '0);
        end
        finish_test("out-of-range addresses");

        $display("tests passed %0d, tests failed %0d, requests %0d, errors %0d",
                 tests_passed, tests_failed, req_count, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req_valid,
    input  wire lsu_pkg::mem_op_e  req_op,
    input  wire axi_pkg::addr_t    req_addr,
    input  wire axi_pkg::data_t    req_wdata,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output axi_pkg::data_t         rsp_rdata,
    output logic                   rsp_err,
    input  wire                    rsp_ready
);

    logic             dec_valid;
    logic             dec_ready;
    lsu_pkg::mem_op_e dec_op;
    axi_pkg::addr_t   dec_addr;
    axi_pkg::strb_t   dec_strb;
    axi_pkg::data_t   dec_wdata;
    logic [1:0]       dec_lane;
    logic             dec_misaligned;
    logic             ex_valid;
    logic             ex_ready;
    lsu_pkg::mem_op_e ex_op;
    logic [1:0]       ex_lane;
    axi_pkg::data_t   ex_rdata;
    logic             ex_err;
    logic             ex_busy;
    logic             res_busy;
    axi_pkg::addr_t   araddr;
    logic             arvalid;
    logic             arready;
    axi_pkg::data_t   rdata;
    axi_pkg::resp_e   rresp;
    logic             rvalid;
    logic             rready;
    axi_pkg::addr_t   awaddr;
    logic             awvalid;
    logic             awready;
    axi_pkg::data_t   wdata;
    axi_pkg::strb_t   wstrb;
    logic             wvalid;
    logic             wready;
    axi_pkg::resp_e   bresp;
    logic             bvalid;
    logic             bready;

    lsu_decode u_decode (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .lsu_busy(ex_busy | res_busy), .req_ready(req_ready),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op),
        .dec_addr(dec_addr), .dec_strb(dec_strb), .dec_wdata(dec_wdata),
        .dec_lane(dec_lane), .dec_misaligned(dec_misaligned)
    );

    lsu_bus_master u_master (
        .clk(clk), .rst(rst),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op),
        .dec_addr(dec_addr), .dec_strb(dec_strb), .dec_wdata(dec_wdata),
        .dec_lane(dec_lane), .dec_misaligned(dec_misaligned),
        .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_op(ex_op), .ex_lane(ex_lane),
        .ex_rdata(ex_rdata), .ex_err(ex_err), .busy(ex_busy),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    lsu_result u_result (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_op(ex_op), .ex_lane(ex_lane),
        .ex_rdata(ex_rdata), .ex_err(ex_err),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
        .rsp_err(rsp_err), .busy(res_busy)
    );

    axi_sram u_sram (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

`default_nettype wire

// File: verilog/axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module axi_sram (
    input  wire                  clk,
    input  wire                  rst,
    input  wire axi_pkg::addr_t  araddr,
    input  wire                  arvalid,
    output logic                 arready,
    output axi_pkg::data_t       rdata,
    output axi_pkg::resp_e       rresp,
    output logic                 rvalid,
    input  wire                  rready,
    input  wire axi_pkg::addr_t  awaddr,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire axi_pkg::data_t  wdata,
    input  wire axi_pkg::strb_t  wstrb,
    input  wire                  wvalid,
    output logic                 wready,
    output axi_pkg::resp_e       bresp,
    output logic                 bvalid,
    input  wire                  bready
);

    localparam int unsigned CNT_W = $clog2(`SRAM_MAX_LAT + 1);
    localparam int unsigned IDX_W = $clog2(`SRAM_WORDS);

    axi_pkg::data_t       mem [0:`SRAM_WORDS-1];
    axi_pkg::addr_t       araddr_q;
    axi_pkg::addr_t       awaddr_q;
    axi_pkg::data_t       wdata_q;
    axi_pkg::strb_t       wstrb_q;
    logic [7:0]           lfsr;
    logic [CNT_W-1:0]     lat_next;
    logic [CNT_W-1:0]     rcnt;
    logic [CNT_W-1:0]     wcnt;
    logic [`ADDR_W-3:0]   rd_idx;
    logic [`ADDR_W-3:0]   wr_idx;
    logic                 rd_ok;
    logic                 wr_ok;

    assign rd_idx = araddr_q[`ADDR_W-1:2];
    assign wr_idx = awaddr_q[`ADDR_W-1:2];
    assign rd_ok = (rd_idx < `SRAM_WORDS);
    assign wr_ok = (wr_idx < `SRAM_WORDS);

    // the latency is folded into 1 to SRAM_MAX_LAT cycles.
    assign lat_next = CNT_W'(lfsr % `SRAM_MAX_LAT) + CNT_W'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `LFSR_SEED;
        end else if ((arvalid && arready) || (wvalid && wready)) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid <= 1'b0;
            rcnt <= '0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rcnt <= lat_next;
            end else if (rcnt != '0) begin
                rcnt <= rcnt - 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                arready <= 1'b1;
            end else if (rcnt == CNT_W'(1)) begin
                rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b1;
            wready <= 1'b1;
            bvalid <= 1'b0;
            wcnt <= '0;
        end else begin
            if (awvalid && awready) awready <= 1'b0;
            // the response delay counts from the write data handshake.
            if (wvalid && wready) begin
                wready <= 1'b0;
                wcnt <= lat_next;
            end else if (wcnt != '0) begin
                wcnt <= wcnt - 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                awready <= 1'b1;
                wready <= 1'b1;
            end else if (wcnt == CNT_W'(1)) begin
                bvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) araddr_q <= araddr;
        if (awvalid && awready) awaddr_q <= awaddr;
        if (wvalid && wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (rcnt == CNT_W'(1)) begin
            rdata <= rd_ok ? mem[rd_idx[IDX_W-1:0]] : '0;
            rresp <= rd_ok ? axi_pkg::OKAY : axi_pkg::SLVERR;
        end
        if (wcnt == CNT_W'(1)) begin
            bresp <= wr_ok ? axi_pkg::OKAY : axi_pkg::SLVERR;
            for (int i = 0; i < `DATA_W / 8; i++) begin
                if (wr_ok && wstrb_q[i]) begin
                    mem[wr_idx[IDX_W-1:0]][8*i +: 8] <= wdata_q[8*i +: 8];
                end
            end
        end
    end

    a_r_hold : assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: verilog/lsu_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module lsu_result (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    ex_valid,
    output logic                   ex_ready,
    input  wire lsu_pkg::mem_op_e  ex_op,
    input  wire [1:0]              ex_lane,
    input  wire axi_pkg::data_t    ex_rdata,
    input  wire                    ex_err,
    output logic                   rsp_valid,
    input  wire                    rsp_ready,
    output axi_pkg::data_t         rsp_rdata,
    output logic                   rsp_err,
    output logic                   busy
);

    axi_pkg::data_t lane_data;
    axi_pkg::data_t ext_data;

    // there is a single response slot, so nothing new enters while one waits.
    assign ex_ready = !rsp_valid;
    assign busy = rsp_valid;

    always_comb begin
        lane_data = ex_rdata >> {ex_lane, 3'b000};
        case (ex_op)
            lsu_pkg::LB:  ext_data = {{(`DATA_W-8){lane_data[7]}}, lane_data[7:0]};
            lsu_pkg::LH:  ext_data = {{(`DATA_W-16){lane_data[15]}}, lane_data[15:0]};
            lsu_pkg::LBU: ext_data = {{(`DATA_W-8){1'b0}}, lane_data[7:0]};
            lsu_pkg::LHU: ext_data = {{(`DATA_W-16){1'b0}}, lane_data[15:0]};
            lsu_pkg::LW:  ext_data = ex_rdata;
            default:      ext_data = '0;
        endcase
        if (ex_err) begin
            ext_data = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (ex_valid && ex_ready) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            rsp_rdata <= ext_data;
            rsp_err <= ex_err;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_bus_master.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_bus_master (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    dec_valid,
    output logic                   dec_ready,
    input  wire lsu_pkg::mem_op_e  dec_op,
    input  wire axi_pkg::addr_t    dec_addr,
    input  wire axi_pkg::strb_t    dec_strb,
    input  wire axi_pkg::data_t    dec_wdata,
    input  wire [1:0]              dec_lane,
    input  wire                    dec_misaligned,
    output logic                   ex_valid,
    input  wire                    ex_ready,
    output lsu_pkg::mem_op_e       ex_op,
    output logic [1:0]             ex_lane,
    output axi_pkg::data_t         ex_rdata,
    output logic                   ex_err,
    output logic                   busy,
    output axi_pkg::addr_t         araddr,
    output logic                   arvalid,
    input  wire                    arready,
    input  wire axi_pkg::data_t    rdata,
    input  wire axi_pkg::resp_e    rresp,
    input  wire                    rvalid,
    output logic                   rready,
    output axi_pkg::addr_t         awaddr,
    output logic                   awvalid,
    input  wire                    awready,
    output axi_pkg::data_t         wdata,
    output axi_pkg::strb_t         wstrb,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire axi_pkg::resp_e    bresp,
    input  wire                    bvalid,
    output logic                   bready
);

    lsu_pkg::exec_state_e state;
    logic                 aw_done;
    logic                 w_done;

    // valids and readies come straight from the state, so they hold until their handshake.
    assign dec_ready = (state == lsu_pkg::IDLE);
    assign busy = (state != lsu_pkg::IDLE);
    assign ex_valid = (state == lsu_pkg::DONE);
    assign arvalid = (state == lsu_pkg::RD_ADDR);
    assign rready = (state == lsu_pkg::RD_DATA);
    assign awvalid = (state == lsu_pkg::WR_REQ) && !aw_done;
    assign wvalid = (state == lsu_pkg::WR_REQ) && !w_done;
    assign bready = (state == lsu_pkg::WR_RESP);
    assign awaddr = araddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::IDLE: begin
                    if (dec_valid && dec_misaligned) begin
                        state <= lsu_pkg::DONE;
                    end else if (dec_valid && dec_op inside {lsu_pkg::SB, lsu_pkg::SH,
                                                           lsu_pkg::SW}) begin
                        state <= lsu_pkg::WR_REQ;
                    end else if (dec_valid) begin
                        state <= lsu_pkg::RD_ADDR;
                    end
                end
                lsu_pkg::RD_ADDR: if (arready) state <= lsu_pkg::RD_DATA;
                lsu_pkg::RD_DATA: if (rvalid) state <= lsu_pkg::DONE;
                lsu_pkg::WR_REQ: begin
                    if (awready) aw_done <= 1'b1;
                    if (wready) w_done <= 1'b1;
                    // the two channels may finish on different edges.
                    if ((aw_done || awready) && (w_done || wready)) begin
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                        state <= lsu_pkg::WR_RESP;
                    end
                end
                lsu_pkg::WR_RESP: if (bvalid) state <= lsu_pkg::DONE;
                lsu_pkg::DONE: if (ex_ready) state <= lsu_pkg::IDLE;
                default: state <= lsu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            ex_op <= dec_op;
            ex_lane <= dec_lane;
            araddr <= dec_addr;
            wdata <= dec_wdata;
            wstrb <= dec_strb;
            ex_rdata <= '0;
            ex_err <= dec_misaligned;
        end else if (rvalid && rready) begin
            ex_rdata <= rdata;
            ex_err <= (rresp != axi_pkg::OKAY);
        end else if (bvalid && bready) begin
            ex_err <= (bresp != axi_pkg::OKAY);
        end
    end

    a_ar_hold : assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // the slave's readies and valids show which channel has a transaction in flight.
    a_one_outstanding : assert property (@(posedge clk) disable iff (rst)
        !((!arready || rvalid) && (!awready || !wready || bvalid)));

endmodule

`default_nettype wire

// File: verilog/lsu_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_params.svh"

module lsu_decode (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req_valid,
    input  wire lsu_pkg::mem_op_e  req_op,
    input  wire axi_pkg::addr_t    req_addr,
    input  wire axi_pkg::data_t    req_wdata,
    input  wire                    lsu_busy,
    output logic                   req_ready,
    output logic                   dec_valid,
    input  wire                    dec_ready,
    output lsu_pkg::mem_op_e       dec_op,
    output axi_pkg::addr_t         dec_addr,
    output axi_pkg::strb_t         dec_strb,
    output axi_pkg::data_t         dec_wdata,
    output logic [1:0]             dec_lane,
    output logic                   dec_misaligned
);

    axi_pkg::strb_t strb_d;
    axi_pkg::data_t wdata_d;
    logic           misaligned_d;

    // only one operation may be anywhere in the LSU at a time.
    assign req_ready = !dec_valid && !lsu_busy;

    always_comb begin
        strb_d = '0;
        wdata_d = req_wdata;
        misaligned_d = 1'b0;
        case (req_op)
            lsu_pkg::SB: begin
                strb_d = 4'b0001 << req_addr[1:0];
                wdata_d = {4{req_wdata[7:0]}};
            end
            lsu_pkg::SH: begin
                strb_d = 4'b0011 << req_addr[1:0];
                wdata_d = {2{req_wdata[15:0]}};
                misaligned_d = req_addr[0];
            end
            lsu_pkg::SW: begin
                strb_d = 4'b1111;
                misaligned_d = (req_addr[1:0] != 2'b00);
            end
            lsu_pkg::LH, lsu_pkg::LHU: misaligned_d = req_addr[0];
            lsu_pkg::LW: misaligned_d = (req_addr[1:0] != 2'b00);
            default: misaligned_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            dec_op <= req_op;
            dec_addr <= {req_addr[`ADDR_W-1:2], 2'b00};
            dec_strb <= strb_d;
            dec_wdata <= wdata_d;
            dec_lane <= req_addr[1:0];
            dec_misaligned <= misaligned_d;
        end
    end

    a_dec_hold : assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_op) && $stable(dec_addr));

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // states of the AXI4-Lite master in the execute stage.
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        RD_ADDR = 3'd1,
        RD_DATA = 3'd2,
        WR_REQ  = 3'd3,
        WR_RESP = 3'd4,
        DONE    = 3'd5
    } exec_state_e;

endpackage

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

`include "mem_params.svh"

package axi_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`DATA_W/8-1:0] strb_t;

    // only the two responses this slave can give are listed.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

`default_nettype wire

// File: verilog/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address and data widths of the load/store path.
`define ADDR_W 32
`define DATA_W 32

// the SRAM holds this many 32-bit words; higher word indices get SLVERR.
`define SRAM_WORDS 256

// largest delay from an AR or W handshake to the matching response.
`define SRAM_MAX_LAT 5

// nonzero reset value of the latency LFSR.
`define LFSR_SEED 8'hA5

`endif
